// ==== verilog.f ====
+incdir+hdl
hdl/csi_pkg.sv
hdl/csi_byte_aligner.sv
hdl/csi_lane_aligner.sv
hdl/csi_packet_decoder.sv
hdl/csi_raw10_depacker.sv
hdl/csi_rx_top.sv
verification/csi_rx_asserts.sv
verification/csi_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the CSI-2 receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ns \
	--top-module csi_rx_tb \
	-f verilog.f

# exit status of the simulation is the result
./obj_dir/Vcsi_rx_tb

// ==== verification/csi_rx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csi_defs.svh"

module csi_rx_tb;

	localparam int kind_fs = 0;
	localparam int kind_fe = 1;
	localparam int kind_line = 2;
	localparam int kind_other = 3;	// long packet that is not RAW10

	typedef struct {
		string name;
		int kind;
		int wc;	// byte count, frame number for short packets
		bit rnd_off;	// random nonzero bit offset per lane
		int skew0;	// extra cycles before the sync byte
		int skew1;
	} row_t;

	logic clk_i;
	logic reset_i;
	logic lp_i;
	csi_pkg::lane_word_t raw_i;
	csi_pkg::pixel_out_s pixels_o;
	logic frame_start_o;
	logic frame_end_o;

	row_t rows[$];
	byte unsigned pkt[$];	// packet bytes in link order
	bit bits0[$];	// serial stream of lane 0, first bit first
	bit bits1[$];
	csi_pkg::pixel_out_s exp_q[$];
	csi_pkg::pixel_out_s got_q[$];
	int fs_cnt;
	int fe_cnt;
	int seed = 32'h9c9f;

	csi_rx_top u_dut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.lp_i(lp_i),
		.raw_i(raw_i),
		.pixels_o(pixels_o),
		.frame_start_o(frame_start_o),
		.frame_end_o(frame_end_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// outputs only move on posedge, so sample here
	always @(posedge clk_i)
	begin
		if (pixels_o.valid)
			got_q.push_back(pixels_o);
		if (frame_start_o)
			fs_cnt++;
		if (frame_end_o)
			fe_cnt++;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pixels(input string name, input csi_pkg::pixel_out_s exp,
		input csi_pkg::pixel_out_s act);
		if (exp !== act)
		begin
			$display("FAILED %s: expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_pulse(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("FAILED %s: expected %b actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act)
		begin
			$display("FAILED %s: expected %0d actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	task automatic add_row(input string name, input int kind, input int wc, input bit rnd_off,
		input int skew0, input int skew1);
		row_t r;
		r.name = name;
		r.kind = kind;
		r.wc = wc;
		r.rnd_off = rnd_off;
		r.skew0 = skew0;
		r.skew1 = skew1;
		rows.push_back(r);
	endtask

	// packet bytes plus the pixels the RAW10 rule gives for them
	task automatic build_packet(input row_t r);
		byte unsigned di;
		csi_pkg::pixel_out_s p;
		pkt.delete();
		exp_q.delete();
		case (r.kind)
			kind_fs: di = 8'h00;
			kind_fe: di = 8'h01;
			kind_line: di = 8'h2B;
			default: di = 8'h12;	// embedded data
		endcase
		pkt.push_back(di);
		pkt.push_back(8'(r.wc));
		pkt.push_back(8'(r.wc >> 8));
		pkt.push_back(8'($random(seed)));	// ecc, not checked
		if (r.kind == kind_line || r.kind == kind_other)
			repeat (r.wc + 2) pkt.push_back(8'($random(seed)));	// payload and crc
		repeat (16) pkt.push_back(8'($random(seed)));	// trailer, 8 per lane
		if (r.kind == kind_line)
		begin
			for (int g = 0; g < r.wc / 5; g++)
			begin
				p.valid = 1'b1;
				p.line_valid = 1'b1;
				for (int k = 0; k < 4; k++)
					p.pixels[k] = {pkt[4 + 5*g + k], 2'(pkt[8 + 5*g] >> (2*k))};
				exp_q.push_back(p);
			end
		end
	endtask

	task automatic add_byte(input int lane, input byte unsigned b);
		for (int i = 0; i < 8; i++)
		begin
			if (lane == 0)
				bits0.push_back(b[i]);	// lsb goes out first
			else
				bits1.push_back(b[i]);
		end
	endtask

	task automatic build_lanes(input row_t r);
		int off0;
		int off1;
		off0 = 0;
		off1 = 0;
		if (r.rnd_off)
		begin
			off0 = 1 + int'($unsigned($random(seed)) % 7);
			off1 = 1 + int'($unsigned($random(seed)) % 7);
		end
		bits0.delete();
		bits1.delete();
		// zero lead-in, skew and bit offset ahead of sync
		repeat (8 * (2 + r.skew0) + off0) bits0.push_back(1'b0);
		repeat (8 * (2 + r.skew1) + off1) bits1.push_back(1'b0);
		add_byte(0, `CSI_SYNC_BYTE);
		add_byte(1, `CSI_SYNC_BYTE);
		for (int n = 0; n < pkt.size(); n++)
			add_byte(n % 2, pkt[n]);
		// pad to the same whole number of bytes
		while (bits0.size() % 8 != 0 || bits0.size() < bits1.size())
			bits0.push_back(1'($random(seed)));
		while (bits1.size() % 8 != 0 || bits1.size() < bits0.size())
			bits1.push_back(1'($random(seed)));
	endtask

	task automatic send_stream();
		csi_pkg::lane_word_t w;
		for (int t = 0; t < bits0.size() / 8; t++)
		begin
			for (int i = 0; i < 8; i++)
			begin
				w[i] = bits0[8*t + i];
				w[8 + i] = bits1[8*t + i];
			end
			@(posedge clk_i);
			lp_i <= 1'b0;
			raw_i <= w;
		end
		@(posedge clk_i);
		lp_i <= 1'b1;	// back to low power
		raw_i <= '0;
	endtask

	task automatic wait_pixels(input string name, input int n);
		int guard;
		guard = 0;
		while (got_q.size() < n)
		begin
			@(negedge clk_i);
			guard++;
			if (guard > 100)
			begin
				$display("%s: timed out waiting for %0d pixel outputs, saw %0d",
					name, n, got_q.size());
				abort_run();
			end
		end
	endtask

	initial
	begin
		reset_i = 1'b1;
		lp_i = 1'b1;
		raw_i = '0;
		fs_cnt = 0;
		fe_cnt = 0;
		add_row("frame_start", kind_fs, 1, 1'b0, 0, 0);
		add_row("line_aligned", kind_line, 10, 1'b0, 0, 0);
		add_row("line_offset", kind_line, 10, 1'b1, 0, 0);
		add_row("line_offset_long", kind_line, 40, 1'b1, 0, 0);
		add_row("line_skew_lane1", kind_line, 20, 1'b0, 0, 3);
		add_row("other_packet", kind_other, 20, 1'b0, 0, 0);
		add_row("line_skew_lane0", kind_line, 30, 1'b1, 2, 0);
		add_row("line_skew_offset", kind_line, 50, 1'b1, 1, 3);
		add_row("frame_end", kind_fe, 2, 1'b0, 0, 0);
		repeat (10) @(posedge clk_i);
		reset_i <= 1'b0;
		repeat (4) @(negedge clk_i);
		foreach (rows[i])
		begin
			got_q.delete();
			fs_cnt = 0;
			fe_cnt = 0;
			build_packet(rows[i]);
			build_lanes(rows[i]);
			send_stream();
			wait_pixels(rows[i].name, exp_q.size());
			repeat (8) @(negedge clk_i);	// lp period, pipeline drains
			check_count({rows[i].name, " pixel count"}, exp_q.size(), got_q.size());
			for (int k = 0; k < exp_q.size(); k++)
				check_pixels(rows[i].name, exp_q[k], got_q[k]);
			check_pulse({rows[i].name, " frame_start"}, rows[i].kind == kind_fs, fs_cnt != 0);
			check_pulse({rows[i].name, " frame_end"}, rows[i].kind == kind_fe, fe_cnt != 0);
			check_count({rows[i].name, " frame_start pulses"},
				(rows[i].kind == kind_fs) ? 1 : 0, fs_cnt);
			check_count({rows[i].name, " frame_end pulses"},
				(rows[i].kind == kind_fe) ? 1 : 0, fe_cnt);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/csi_rx_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module csi_rx_asserts (
	input logic clk_i,
	input logic reset_i,
	input csi_pkg::pixel_out_s pixels_i,
	input logic frame_start_i,
	input logic frame_end_i
);

	// each marker comes from its own short packet
	a_frame_excl: assert property (@(posedge clk_i) !(frame_start_i && frame_end_i))
		else $error("frame start and frame end high in the same cycle");

	a_valid_in_line: assert property (@(posedge clk_i)
		pixels_i.valid |-> pixels_i.line_valid)
		else $error("pixel valid outside an active line");

	// registered outputs clear one edge into reset
	a_quiet_in_reset: assert property (@(posedge clk_i)
		reset_i |=> !pixels_i.valid && !pixels_i.line_valid && !frame_start_i && !frame_end_i)
		else $error("output active during reset");

endmodule

bind csi_rx_top csi_rx_asserts u_asserts (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.pixels_i(pixels_o),
	.frame_start_i(frame_start_o),
	.frame_end_i(frame_end_o)
);

`default_nettype wire

// ==== hdl/csi_rx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csi_defs.svh"

module csi_rx_top (
	input logic clk_i,
	input logic reset_i,
	input logic lp_i,	// lane 0 low-power state
	input csi_pkg::lane_word_t raw_i,	// deserialized bytes, lane 0 low
	output csi_pkg::pixel_out_s pixels_o,
	output logic frame_start_o,
	output logic frame_end_o
);

	csi_pkg::lane_bytes_t [`CSI_LANES-1:0] lane_bytes;
	csi_pkg::lane_word_s lane_word;
	csi_pkg::payload_s payload;

	// one bit aligner per lane
	for (genvar i = 0; i < `CSI_LANES; i++)
	begin : g_lane
		csi_byte_aligner u_byte_aligner (
			.clk_i(clk_i),
			.reset_i(reset_i),
			.lp_i(lp_i),
			.byte_i(raw_i[i*`CSI_GEAR +: `CSI_GEAR]),
			.aligned_o(lane_bytes[i])
		);
	end

	csi_lane_aligner u_lane_aligner (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.lp_i(lp_i),
		.lanes_i(lane_bytes),
		.word_o(lane_word)
	);

	// frame sync taken from the frame start packet
	csi_packet_decoder u_packet_decoder (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.word_i(lane_word),
		.payload_o(payload),
		.frame_start_o(frame_start_o),
		.frame_end_o(frame_end_o)
	);

	csi_raw10_depacker u_raw10_depacker (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.payload_i(payload),
		.pixels_o(pixels_o)	// four pixels per valid
	);

endmodule

`default_nettype wire

// ==== hdl/csi_raw10_depacker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csi_defs.svh"

module csi_raw10_depacker (
	input logic clk_i,
	input logic reset_i,
	input csi_pkg::payload_s payload_i,
	output csi_pkg::pixel_out_s pixels_o
);

	// five bytes hold four pixels: four msb bytes, then the packed lsbs
	logic [47:0] buf_q;	// up to 4 leftover bytes plus the new word
	logic [2:0] cnt_q;	// bytes held in buf_q
	logic [5:0] shift;
	logic [47:0] mask;
	logic [47:0] merged;
	logic [2:0] fill;
	logic [39:0] group;
	logic [`CSI_PIX_PER_CLK-1:0][`CSI_PIX_W-1:0] pix;
	logic [`CSI_PIX_PER_CLK-1:0][`CSI_PIX_W-1:0] pix_q;
	logic valid_q;
	logic line_valid_q;

	always_comb
	begin
		shift = {cnt_q, 3'b000};	// byte count to bit offset
		mask = (48'd1 << shift) - 48'd1;	// keeps only the held bytes
		merged = (buf_q & mask) | ({32'd0, payload_i.data} << shift);
		fill = cnt_q + 3'd2;
		group = merged[39:0];
		for (int k = 0; k < `CSI_PIX_PER_CLK; k++)
		begin
			// msbs from byte k, lsbs from the fifth byte
			pix[k] = {group[k*8 +: 8], group[32 + 2*k +: 2]};
		end
	end

	// byte data, no reset
	always_ff @(posedge clk_i)
	begin
		if (payload_i.valid)
		begin
			if (fill >= 3'd5)
			begin
				buf_q <= merged >> 40;	// leftover byte moves to the bottom
				pix_q <= pix;
			end
			else
			begin
				buf_q <= merged;
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			cnt_q <= 3'd0;
			valid_q <= 1'b0;
			line_valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			line_valid_q <= payload_i.line_active;
			if (!payload_i.line_active)
			begin
				cnt_q <= 3'd0;	// drop partial group at line end
			end
			else if (payload_i.valid)
			begin
				if (fill >= 3'd5)
				begin
					cnt_q <= fill - 3'd5;	// words 3 and 5 of each five
					valid_q <= 1'b1;
				end
				else
				begin
					cnt_q <= fill;
				end
			end
		end
	end

	always_comb
	begin
		pixels_o.valid = valid_q;
		pixels_o.line_valid = line_valid_q;
		pixels_o.pixels = pix_q;
	end

endmodule

`default_nettype wire

// ==== hdl/csi_packet_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module csi_packet_decoder (
	input logic clk_i,
	input logic reset_i,
	input csi_pkg::lane_word_s word_i,
	output csi_pkg::payload_s payload_o,
	output logic frame_start_o,
	output logic frame_end_o
);

	csi_pkg::dec_state_e state_q;
	csi_pkg::data_type_e dt_q;	// from the first header word
	logic [7:0] wc_lo_q;
	logic [14:0] words_left_q;	// payload words still to pass
	logic [14:0] words;
	logic pay_valid_q;
	logic line_q;
	csi_pkg::lane_word_t pay_data_q;

	// word count is in bytes with two bytes per lane word
	assign words = {word_i.data[7:0], wc_lo_q[7:1]};

	// header fields from the first word
	always_ff @(posedge clk_i)
	begin
		if (word_i.valid && state_q == csi_pkg::HEADER0)
		begin
			dt_q <= csi_pkg::data_type_e'(word_i.data[5:0]);	// vc bits ignored
			wc_lo_q <= word_i.data[15:8];
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (word_i.valid)
		begin
			pay_data_q <= word_i.data;	// one cycle of latency
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q <= csi_pkg::HEADER0;
			words_left_q <= '0;
			pay_valid_q <= 1'b0;
			line_q <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o <= 1'b0;
		end
		else
		begin
			// pulses and payload valid last one cycle
			pay_valid_q <= 1'b0;
			line_q <= 1'b0;
			frame_start_o <= 1'b0;
			frame_end_o <= 1'b0;

			if (!word_i.valid)
			begin
				state_q <= csi_pkg::HEADER0;	// next burst starts with a header
			end
			else
			begin
				case (state_q)
					csi_pkg::HEADER0:
					begin
						state_q <= csi_pkg::HEADER1;
					end

					csi_pkg::HEADER1:
					begin
						state_q <= csi_pkg::DISCARD;	// unless a line follows
						case (dt_q)
							csi_pkg::FRAME_START: frame_start_o <= 1'b1;
							csi_pkg::FRAME_END: frame_end_o <= 1'b1;
							csi_pkg::RAW10:
							begin
								if (words != 15'd0)
								begin
									words_left_q <= words;
									line_q <= 1'b1;	// line opens a cycle before data
									state_q <= csi_pkg::PAYLOAD;
								end
							end
							default:
							begin
								state_q <= csi_pkg::DISCARD;	// other packets dropped
							end
						endcase
					end

					csi_pkg::PAYLOAD:
					begin
						pay_valid_q <= 1'b1;
						line_q <= 1'b1;
						words_left_q <= words_left_q - 15'd1;
						if (words_left_q == 15'd1)
						begin
							state_q <= csi_pkg::DISCARD;	// crc and trailer follow
						end
					end

					default:
					begin
						state_q <= csi_pkg::DISCARD;	// wait for valid to drop
					end
				endcase
			end
		end
	end

	always_comb
	begin
		payload_o.valid = pay_valid_q;
		payload_o.line_active = line_q;
		payload_o.data = pay_data_q;
	end

endmodule

`default_nettype wire

// ==== hdl/csi_lane_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csi_defs.svh"

module csi_lane_aligner (
	input logic clk_i,
	input logic reset_i,
	input logic lp_i,
	input csi_pkg::lane_bytes_t [`CSI_LANES-1:0] lanes_i,
	output csi_pkg::lane_word_s word_o
);

	// four taps per lane, so up to 3 cycles of skew
	logic [`CSI_LANES-1:0][3:0][`CSI_GEAR-1:0] hist_q;
	logic [`CSI_LANES-1:0][1:0] run_q;	// cycles each lane has been valid so far
	logic [`CSI_LANES-1:0][1:0] dly_q;	// tap picked per lane
	logic [`CSI_LANES-1:0] lane_valid;
	logic locked_q;

	always_comb
	begin
		for (int l = 0; l < `CSI_LANES; l++)
		begin
			lane_valid[l] = lanes_i[l].valid;
		end
	end

	// history shift, tap 0 is one cycle old
	always_ff @(posedge clk_i)
	begin
		for (int l = 0; l < `CSI_LANES; l++)
		begin
			hist_q[l][0] <= lanes_i[l].data;
			for (int k = 1; k < 4; k++)
			begin
				hist_q[l][k] <= hist_q[l][k-1];
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (reset_i || lp_i)
		begin
			locked_q <= 1'b0;
			run_q <= '0;
			dly_q <= '0;
		end
		else if (!locked_q)
		begin
			for (int l = 0; l < `CSI_LANES; l++)
			begin
				if (lane_valid[l] && run_q[l] != 2'd3)
				begin
					run_q[l] <= run_q[l] + 2'd1;	// saturates at max skew
				end
			end
			// last lane just came up, early lanes read older taps
			if (&lane_valid)
			begin
				locked_q <= 1'b1;
				dly_q <= run_q;
			end
		end
	end

	// one word, one valid; rises a cycle after the latest lane
	always_comb
	begin
		word_o.valid = locked_q;
		for (int l = 0; l < `CSI_LANES; l++)
		begin
			word_o.data[l*`CSI_GEAR +: `CSI_GEAR] = hist_q[l][dly_q[l]];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/csi_byte_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "csi_defs.svh"

module csi_byte_aligner (
	input logic clk_i,
	input logic reset_i,
	input logic lp_i,	// lane in low-power state, drops the lock
	input logic [`CSI_GEAR-1:0] byte_i,
	output csi_pkg::lane_bytes_t aligned_o
);

	logic [`CSI_GEAR-1:0] cur_q;	// newest raw byte
	logic [`CSI_GEAR-1:0] prev_q;	// raw byte before that
	logic [2*`CSI_GEAR-1:0] window;
	logic locked_q;
	logic [2:0] offset_q;	// bit position of the sync byte in the window
	logic found;
	logic [2:0] found_offset;

	// raw history, earlier bits in the low half
	always_ff @(posedge clk_i)
	begin
		cur_q <= byte_i;
		prev_q <= cur_q;
	end

	assign window = {cur_q, prev_q};

	// scan every bit offset for the sync pattern
	always_comb
	begin
		found = 1'b0;
		found_offset = 3'd0;
		for (int o = `CSI_GEAR - 1; o >= 0; o--)
		begin
			if (window[o +: `CSI_GEAR] == `CSI_SYNC_BYTE)
			begin
				found = 1'b1;	// lowest offset wins
				found_offset = 3'(o);
			end
		end
	end

	// lock on first hit, hold until low power
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			locked_q <= 1'b0;
			offset_q <= 3'd0;
		end
		else if (lp_i)
		begin
			locked_q <= 1'b0;
			offset_q <= 3'd0;
		end
		else if (!locked_q && found)
		begin
			locked_q <= 1'b1;
			offset_q <= found_offset;	// next window starts at the byte after sync
		end
	end

	// byte carried by a raw byte shows up two cycles later
	always_comb
	begin
		aligned_o.valid = locked_q;
		aligned_o.data = window[offset_q +: `CSI_GEAR];
	end

endmodule

`default_nettype wire

// ==== hdl/csi_pkg.sv ====
`default_nettype none

package csi_pkg;

	`include "csi_defs.svh"

	// byte 0 from lane 0 sits in the low bits
	typedef logic [`CSI_LANES*`CSI_GEAR-1:0] lane_word_t;

	// one lane after bit alignment
	typedef struct packed {
		logic valid;
		logic [`CSI_GEAR-1:0] data;
	} lane_bytes_t;

	// deskewed word of all lanes
	typedef struct packed {
		logic valid;
		lane_word_t data;
	} lane_word_s;

	// data identifier, low six bits (vc bits dropped)
	typedef enum logic [5:0] {
		FRAME_START = 6'h00,
		FRAME_END = 6'h01,
		LINE_START = 6'h02,
		LINE_END = 6'h03,
		RAW10 = 6'h2B
	} data_type_e;

	typedef enum logic [1:0] {
		HEADER0,	// DI and wc low byte
		HEADER1,	// wc high byte and ECC
		PAYLOAD,
		DISCARD	// crc, trailer, unwanted packets
	} dec_state_e;

	typedef struct packed {
		logic valid;
		logic line_active;	// spans the RAW10 payload
		lane_word_t data;
	} payload_s;

	typedef struct packed {
		logic valid;
		logic line_valid;
		logic [`CSI_PIX_PER_CLK-1:0][`CSI_PIX_W-1:0] pixels;	// pixel 0 in low bits
	} pixel_out_s;

endpackage

`default_nettype wire

// ==== hdl/csi_defs.svh ====
`ifndef CSI_DEFS_SVH
`define CSI_DEFS_SVH

// link shape, two lanes at gear 8
`define CSI_LANES 2
`define CSI_GEAR 8

// RAW10 pixel output
`define CSI_PIX_W 10
`define CSI_PIX_PER_CLK 4

// HS sync pattern at the start of each burst
`define CSI_SYNC_BYTE 8'hB8

`endif
